// File: logic/cmp_cfg_pkg.sv
// Lane count, operand width, lane index width and tournament depth constants
package cmp_cfg_pkg;

	// =========================================================================
	// Datapath geometry
	// =========================================================================

	// Operand lanes per sample
	// Must be a power of two for the halving rounds
	localparam int LANES = 8;

	// Operand width in bits
	localparam int DATA_W = 16;

	// Bits needed to name one lane
	localparam int IDX_W = $clog2(LANES);

	// =========================================================================
	// Pipeline depth
	// =========================================================================

	// One registered halving round per index bit
	// Also the top level latency in cycles
	localparam int STAGES = IDX_W;

endpackage

// File: logic/cmp_types_pkg.sv
// Mode, lane entry, comparator flag and input sample structs
package cmp_types_pkg;

	// =========================================================================
	// Control
	// =========================================================================

	// Per-sample operating mode
	typedef struct packed {
		// Operands are two's complement
		logic is_signed;
		// Largest value wins when set, smallest otherwise
		logic find_max;
	} mode_t;

	// =========================================================================
	// Datapath
	// =========================================================================

	// One competitor in the tournament
	typedef struct packed {
		logic [cmp_cfg_pkg::DATA_W-1:0] value;
		// Original lane, kept for the result and the tie break
		logic [cmp_cfg_pkg::IDX_W-1:0]  lane;
	} entry_t;

	// Comparator result, always x relative to y
	// Exactly one bit high for any input pair
	typedef struct packed {
		logic less;
		logic equal;
		logic greater;
	} cmp_flags_t;

	// Top level input word
	// Operand l belongs to lane l
	typedef struct packed {
		logic [cmp_cfg_pkg::LANES-1:0][cmp_cfg_pkg::DATA_W-1:0] operands;
		mode_t                                                  mode;
	} sample_t;

endpackage

// File: logic/cmp_compress_cell.sv
// Two-bit compressor cell with unsigned and signed truth tables
`timescale 1ns/1ps

// Maps a pair of 2-bit digits to one bit per side
// Order of the outputs follows order of the inputs
// Equal and zero gives 0/0, equal and nonzero gives 1/1
// Signed table treats the upper input bit as a sign bit and
// reports the order inverted (x<y gives 1/0)
module cmp_compress_cell #(
	parameter bit SIGNED_CELL = 1'b0
) (
	input  logic [1:0] i_x,
	input  logic [1:0] i_y,
	output logic       o_x,
	output logic       o_y
);

	// {o_x, o_y}
	logic [1:0] res;

	generate
		if (SIGNED_CELL) begin : g_signed
			// Digits are {sign, magnitude} pairs, range -2..1
			always_comb begin
				case ({i_x, i_y})
					4'b00_00: res = 2'b00;
					4'b00_01: res = 2'b10;
					4'b00_10: res = 2'b01;
					4'b00_11: res = 2'b01;
					4'b01_00: res = 2'b01;
					4'b01_01: res = 2'b11;
					4'b01_10: res = 2'b01;
					4'b01_11: res = 2'b01;
					4'b10_00: res = 2'b10;
					4'b10_01: res = 2'b10;
					4'b10_10: res = 2'b11;
					4'b10_11: res = 2'b10;
					4'b11_00: res = 2'b10;
					4'b11_01: res = 2'b10;
					4'b11_10: res = 2'b01;
					default:  res = 2'b11;
				endcase
			end
		end else begin : g_unsigned
			// Plain 2-bit magnitudes, range 0..3
			always_comb begin
				case ({i_x, i_y})
					4'b00_00: res = 2'b00;
					4'b00_01: res = 2'b01;
					4'b00_10: res = 2'b01;
					4'b00_11: res = 2'b01;
					4'b01_00: res = 2'b10;
					4'b01_01: res = 2'b11;
					4'b01_10: res = 2'b01;
					4'b01_11: res = 2'b01;
					4'b10_00: res = 2'b10;
					4'b10_01: res = 2'b10;
					4'b10_10: res = 2'b11;
					4'b10_11: res = 2'b01;
					4'b11_00: res = 2'b10;
					4'b11_01: res = 2'b10;
					4'b11_10: res = 2'b10;
					default:  res = 2'b11;
				endcase
			end
		end
	endgenerate

	assign o_x = res[1];
	assign o_y = res[0];

endmodule

// File: logic/cmp_compress_tree.sv
// Recursive unsigned compressor tree reducing two words to one bit per side
`timescale 1ns/1ps

// =============================================================================
// Unsigned compressor tree
// =============================================================================
// Each level packs adjacent bit pairs into unsigned cells
// Odd top bit skips the level unchanged
// Recursion stops at one bit per side
// Size linear in WIDTH, depth log2(WIDTH)
// Result keeps the cell encoding
//   x>y  gives 1/0
//   x<y  gives 0/1
//   x==y gives 0/0 for zero, 1/1 otherwise
module cmp_compress_tree #(
	// At least 1
	parameter int WIDTH = 2
) (
	input  logic [WIDTH-1:0] i_x,
	input  logic [WIDTH-1:0] i_y,
	output logic             o_x,
	output logic             o_y
);

	generate
		if (WIDTH == 1) begin : g_leaf
			// Single bit already in cell form
			assign o_x = i_x[0];
			assign o_y = i_y[0];
		end else begin : g_level
			// One bit per pair plus the odd top bit
			logic [(WIDTH+1)/2-1:0] lvl_x;
			logic [(WIDTH+1)/2-1:0] lvl_y;

			// Higher pairs land on higher bits so significance is kept
			for (genvar p = 0; p < WIDTH / 2; p++) begin : g_pair
				cmp_compress_cell #(
					.SIGNED_CELL (1'b0)
				) u_cell (
					.i_x (i_x[2*p+1 -: 2]),
					.i_y (i_y[2*p+1 -: 2]),
					.o_x (lvl_x[p]),
					.o_y (lvl_y[p])
				);
			end

			// Unpaired MSB
			if (WIDTH % 2 == 1) begin : g_tail
				assign lvl_x[(WIDTH+1)/2-1] = i_x[WIDTH-1];
				assign lvl_y[(WIDTH+1)/2-1] = i_y[WIDTH-1];
			end

			// Next level on the half-width result
			cmp_compress_tree #(
				.WIDTH ((WIDTH + 1) / 2)
			) u_next (
				.i_x (lvl_x),
				.i_y (lvl_y),
				.o_x (o_x),
				.o_y (o_y)
			);
		end
	endgenerate

endmodule

// File: logic/magnitude_comparator.sv
// Magnitude comparator with signed and unsigned paths over one compressor tree
`timescale 1ns/1ps

// =============================================================================
// Magnitude comparator
// =============================================================================
// Shared tree reduces the low WIDTH-1 bits
// Top bit joins at a root cell, unsigned or signed
// Purely combinational
module magnitude_comparator #(
	// At least 2, top bit is the sign in signed mode
	parameter int WIDTH = 16
) (
	input  logic [WIDTH-1:0]          i_x,
	input  logic [WIDTH-1:0]          i_y,
	input  logic                      i_signed,
	output cmp_types_pkg::cmp_flags_t o_flags
);

	// Low bits reduced to one bit per side
	logic tree_x;
	logic tree_y;
	// Unsigned root, x>y gives 1/0
	logic uns_x;
	logic uns_y;
	// Signed root, x<y gives 1/0
	logic sgn_x;
	logic sgn_y;
	// Selected root in the unsigned sense
	logic res_x;
	logic res_y;

	// =========================================================================
	// Shared tree
	// =========================================================================

	cmp_compress_tree #(
		.WIDTH (WIDTH - 1)
	) u_tree (
		.i_x (i_x[WIDTH-2:0]),
		.i_y (i_y[WIDTH-2:0]),
		.o_x (tree_x),
		.o_y (tree_y)
	);

	// =========================================================================
	// Root cells
	// =========================================================================

	// Top bit is the upper digit bit, tree result the lower one
	cmp_compress_cell #(
		.SIGNED_CELL (1'b0)
	) u_root_unsigned (
		.i_x ({i_x[WIDTH-1], tree_x}),
		.i_y ({i_y[WIDTH-1], tree_y}),
		.o_x (uns_x),
		.o_y (uns_y)
	);

	// Top bit acts as the digit sign here
	cmp_compress_cell #(
		.SIGNED_CELL (1'b1)
	) u_root_signed (
		.i_x ({i_x[WIDTH-1], tree_x}),
		.i_y ({i_y[WIDTH-1], tree_y}),
		.o_x (sgn_x),
		.o_y (sgn_y)
	);

	// =========================================================================
	// Decode
	// =========================================================================

	// Signed root reports the order inverted
	// Swapping its bits restores the unsigned sense
	assign res_x = i_signed ? sgn_y : uns_x;
	assign res_y = i_signed ? sgn_x : uns_y;

	// {less, equal, greater}
	// 1/0 greater, 0/1 less, 0/0 and 1/1 equal
	assign o_flags = {~res_x & res_y, ~(res_x ^ res_y), res_x & ~res_y};

endmodule

// File: logic/tournament_stage.sv
// One registered tournament round that halves the number of entries
`timescale 1ns/1ps

// =============================================================================
// Tournament round
// =============================================================================
// Entry 2j plays entry 2j+1, lower index is a, higher index is b
// Max mode   b wins only when b > a
// Min mode   b wins only when b < a
// Anything else keeps a so ties go to the lower original lane
// One cycle from i_valid to o_valid
module tournament_stage #(
	// Entries coming in (8, 4 or 2)
	parameter int N_IN = 8
) (
	input  logic                                 i_clk,
	input  logic                                 i_arst_n,
	input  logic                                 i_valid,
	input  cmp_types_pkg::entry_t [N_IN-1:0]     i_entries,
	input  cmp_types_pkg::mode_t                 i_mode,
	output logic                                 o_valid,
	output cmp_types_pkg::entry_t [N_IN/2-1:0]   o_entries,
	output cmp_types_pkg::mode_t                 o_mode
);

	// Per match comparator result, b relative to a
	cmp_types_pkg::cmp_flags_t [N_IN/2-1:0] flags;
	// Match outcome, high when the upper entry takes the match
	logic                      [N_IN/2-1:0] b_wins;
	// Combinational winners ahead of the output register
	cmp_types_pkg::entry_t     [N_IN/2-1:0] winners;

	// =========================================================================
	// Matches
	// =========================================================================

	generate
		for (genvar j = 0; j < N_IN / 2; j++) begin : g_match
			// x is b, y is a
			magnitude_comparator #(
				.WIDTH (cmp_cfg_pkg::DATA_W)
			) u_cmp (
				.i_x      (i_entries[2*j+1].value),
				.i_y      (i_entries[2*j].value),
				.i_signed (i_mode.is_signed),
				.o_flags  (flags[j])
			);

			// Strict compare only, equal never moves the win to b
			assign b_wins[j] = i_mode.find_max ? flags[j].greater : flags[j].less;

			assign winners[j] = b_wins[j] ? i_entries[2*j+1] : i_entries[2*j];
		end
	endgenerate

	// =========================================================================
	// Output register
	// =========================================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid   <= 1'b0;
			o_entries <= '0;
			o_mode    <= '0;
		end else begin
			// Strobe follows input every cycle
			o_valid <= i_valid;
			// Payload and mode only move with a sample
			if (i_valid) begin
				o_entries <= winners;
				o_mode    <= i_mode;
			end
		end
	end

endmodule

// File: logic/extremum_finder.sv
// Top level extremum finder chaining three tournament rounds
`timescale 1ns/1ps

// =============================================================================
// Extremum finder
// =============================================================================
// Eight lanes in, one winner and its lane out
// Fixed latency of cmp_cfg_pkg::STAGES cycles
// New sample accepted every cycle, no back-pressure
// Mode travels with its sample through every round
module extremum_finder (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_valid,
	input  cmp_types_pkg::sample_t i_sample,
	output logic                   o_valid,
	output cmp_types_pkg::entry_t  o_winner,
	output cmp_types_pkg::mode_t   o_mode
);

	// Tagged operands feeding round one
	cmp_types_pkg::entry_t [cmp_cfg_pkg::LANES-1:0]   lane_entries;

	// Round one to round two
	logic                                             s1_valid;
	cmp_types_pkg::entry_t [cmp_cfg_pkg::LANES/2-1:0] s1_entries;
	cmp_types_pkg::mode_t                             s1_mode;

	// Round two to round three
	logic                                             s2_valid;
	cmp_types_pkg::entry_t [cmp_cfg_pkg::LANES/4-1:0] s2_entries;
	cmp_types_pkg::mode_t                             s2_mode;

	// Final round output, a single entry
	cmp_types_pkg::entry_t [cmp_cfg_pkg::LANES/8-1:0] s3_entries;

	// Lane tag is the operand's position in the sample
	generate
		for (genvar l = 0; l < cmp_cfg_pkg::LANES; l++) begin : g_tag
			assign lane_entries[l].value = i_sample.operands[l];
			assign lane_entries[l].lane  = cmp_cfg_pkg::IDX_W'(l);
		end
	endgenerate

	// 8 to 4
	tournament_stage #(
		.N_IN (cmp_cfg_pkg::LANES)
	) u_stage1 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_valid   (i_valid),
		.i_entries (lane_entries),
		.i_mode    (i_sample.mode),
		.o_valid   (s1_valid),
		.o_entries (s1_entries),
		.o_mode    (s1_mode)
	);

	// 4 to 2
	tournament_stage #(
		.N_IN (cmp_cfg_pkg::LANES / 2)
	) u_stage2 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_valid   (s1_valid),
		.i_entries (s1_entries),
		.i_mode    (s1_mode),
		.o_valid   (s2_valid),
		.o_entries (s2_entries),
		.o_mode    (s2_mode)
	);

	// 2 to 1
	tournament_stage #(
		.N_IN (cmp_cfg_pkg::LANES / 4)
	) u_stage3 (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_valid   (s2_valid),
		.i_entries (s2_entries),
		.i_mode    (s2_mode),
		.o_valid   (o_valid),
		.o_entries (s3_entries),
		.o_mode    (o_mode)
	);

	assign o_winner = s3_entries[0];

endmodule

// File: tests/tb_extremum_finder.sv
// Directed testbench for the extremum finder with reference model, result monitor and watchdog
`timescale 1ns/1ps

module tb_extremum_finder;

	// =========================================================================
	// Run parameters
	// =========================================================================

	localparam time CLK_PERIOD   = 100ns;
	localparam time DRIVE_DELAY  = 1ns;
	localparam int  RESET_CYCLES = 10;
	localparam int  LATENCY      = cmp_cfg_pkg::STAGES;
	localparam int  LANES        = cmp_cfg_pkg::LANES;
	localparam int  DW           = cmp_cfg_pkg::DATA_W;
	localparam int  IW           = cmp_cfg_pkg::IDX_W;

	// Samples per test
	localparam int N_LATENCY  = 1;
	localparam int N_UNSIGNED = 2 * LANES + 2;
	localparam int N_SIGNED   = 4;
	localparam int N_TIES     = 6;
	localparam int N_STREAM   = 200;
	localparam int TOTAL_SAMPLES = N_LATENCY + N_UNSIGNED + N_SIGNED + N_TIES + N_STREAM;
	localparam int MARGIN_CYCLES = 50;

	// Cycles allowed for the last results after the input goes idle
	localparam int DRAIN_LIMIT = LATENCY + 4;

	// =========================================================================
	// DUT and signals
	// =========================================================================

	logic                   i_clk;
	logic                   i_arst_n;
	logic                   i_valid;
	cmp_types_pkg::sample_t i_sample;
	logic                   o_valid;
	cmp_types_pkg::entry_t  o_winner;
	cmp_types_pkg::mode_t   o_mode;

	// Expected results, oldest first
	cmp_types_pkg::entry_t exp_entry_q[$];
	cmp_types_pkg::mode_t  exp_mode_q[$];
	// Cycle in which each result is due
	int                    exp_due_q[$];

	int cyc_count    = 0;
	int error_count  = 0;
	int check_count  = 0;
	int test_count   = 0;
	int failed_tests = 0;
	int valid_count  = 0;

	extremum_finder u_dut (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_sample (i_sample),
		.o_valid  (o_valid),
		.o_winner (o_winner),
		.o_mode   (o_mode)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// Rising edge count, the time base for latency checks
	always @(posedge i_clk) begin
		cyc_count <= cyc_count + 1;
	end

	// =========================================================================
	// Reference model and sample builders
	// =========================================================================

	// First lane reaching the extremum wins, strict compare only
	function automatic cmp_types_pkg::entry_t ref_winner(input cmp_types_pkg::sample_t s);
		cmp_types_pkg::entry_t best;
		logic [DW-1:0]         v;
		logic                  beats;
		best.value = s.operands[0];
		best.lane  = '0;
		for (int l = 1; l < LANES; l++) begin
			v = s.operands[l];
			if (s.mode.is_signed) begin
				beats = s.mode.find_max ? ($signed(v) > $signed(best.value))
				                        : ($signed(v) < $signed(best.value));
			end else begin
				beats = s.mode.find_max ? (v > best.value) : (v < best.value);
			end
			if (beats) begin
				best.value = v;
				best.lane  = IW'(l);
			end
		end
		return best;
	endfunction

	function automatic cmp_types_pkg::mode_t make_mode(input logic is_signed,
	                                                   input logic find_max);
		cmp_types_pkg::mode_t m;
		m.is_signed = is_signed;
		m.find_max  = find_max;
		return m;
	endfunction

	function automatic cmp_types_pkg::entry_t make_entry(input logic [DW-1:0] value,
	                                                     input int lane);
		cmp_types_pkg::entry_t e;
		e.value = value;
		e.lane  = IW'(lane);
		return e;
	endfunction

	// Same operand in every lane
	function automatic cmp_types_pkg::sample_t fill_sample(input logic [DW-1:0] value,
	                                                       input cmp_types_pkg::mode_t mode);
		cmp_types_pkg::sample_t s;
		for (int l = 0; l < LANES; l++) begin
			s.operands[l] = value;
		end
		s.mode = mode;
		return s;
	endfunction

	// =========================================================================
	// Driver and result monitor
	// =========================================================================

	// One sample per call, calls in a row give back-to-back strobes
	task automatic send_sample(input cmp_types_pkg::sample_t s, input cmp_types_pkg::entry_t exp);
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_valid  = 1'b1;
		i_sample = s;
		exp_entry_q.push_back(exp);
		exp_mode_q.push_back(s.mode);
		exp_due_q.push_back(cyc_count + LATENCY);
	endtask

	task automatic check_result();
		cmp_types_pkg::entry_t exp_e;
		cmp_types_pkg::mode_t  exp_m;
		int                    due;
		exp_e = exp_entry_q.pop_front();
		exp_m = exp_mode_q.pop_front();
		due   = exp_due_q.pop_front();
		check_count = check_count + 1;
		if (due != cyc_count) begin
			$display("[FAIL] %0t: result in cycle %0d, expected in cycle %0d",
			         $time, cyc_count, due);
			error_count = error_count + 1;
		end
		if (o_winner.value !== exp_e.value || o_winner.lane !== exp_e.lane) begin
			$display("[FAIL] %0t: winner value %h lane %0d, expected value %h lane %0d",
			         $time, o_winner.value, o_winner.lane, exp_e.value, exp_e.lane);
			error_count = error_count + 1;
		end
		if (o_mode !== exp_m) begin
			$display("[FAIL] %0t: o_mode %b, expected %b", $time, o_mode, exp_m);
			error_count = error_count + 1;
		end
	endtask

	// Falling edge, outputs settled since the last rising edge
	always @(negedge i_clk) begin
		if (i_arst_n) begin
			if (o_valid === 1'b1) begin
				valid_count = valid_count + 1;
				if (exp_due_q.size() == 0) begin
					$display("Error at %0t: o_valid pulsed with no sample outstanding", $time);
					error_count = error_count + 1;
				end else begin
					check_result();
				end
			end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc_count) begin
				$display("Error at %0t: no o_valid %0d cycles after a sample", $time, LATENCY);
				error_count = error_count + 1;
				void'(exp_entry_q.pop_front());
				void'(exp_mode_q.pop_front());
				void'(exp_due_q.pop_front());
			end
		end
	end

	// Stop driving, then wait for every outstanding result
	task automatic wait_results();
		int waited;
		waited = 0;
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_valid = 1'b0;
		while (exp_due_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge i_clk);
			waited = waited + 1;
		end
		if (exp_due_q.size() != 0) begin
			$display("Error at %0t: results still outstanding after the pipeline drained", $time);
			error_count = error_count + 1;
			exp_entry_q.delete();
			exp_mode_q.delete();
			exp_due_q.delete();
		end
		// One more idle cycle, already seen by the monitor
		@(posedge i_clk);
	endtask

	task automatic report_test(input string name, input int err_before);
		test_count = test_count + 1;
		if (error_count != err_before) begin
			failed_tests = failed_tests + 1;
		end
		$display("Test %-14s finished with %0d errors", name, error_count - err_before);
	endtask

	// =========================================================================
	// Tests
	// =========================================================================

	task automatic test_reset_latency();
		cmp_types_pkg::sample_t s;
		int                     err_before;
		int                     pulses_before;
		err_before    = error_count;
		pulses_before = valid_count;
		// Pipeline empty after reset
		repeat (2) begin
			@(negedge i_clk);
			check_count = check_count + 1;
			if (o_valid !== 1'b0) begin
				$display("[FAIL] %0t: o_valid is %b after reset with no sample", $time, o_valid);
				error_count = error_count + 1;
			end
		end
		s = fill_sample(16'h0042, make_mode(1'b0, 1'b1));
		s.operands[4] = 16'h0099;
		send_sample(s, make_entry(16'h0099, 4));
		wait_results();
		// One strobe in, exactly one strobe out
		check_count = check_count + 1;
		if (valid_count - pulses_before != 1) begin
			$display("Error at %0t: expected one o_valid pulse, saw %0d", $time,
			         valid_count - pulses_before);
			error_count = error_count + 1;
		end
		report_test("reset_latency", err_before);
	endtask

	task automatic test_unsigned();
		cmp_types_pkg::sample_t s;
		int                     err_before;
		err_before = error_count;
		// Full scale against zero, winner in each lane
		for (int w = 0; w < LANES; w++) begin
			s = fill_sample(16'h0000, make_mode(1'b0, 1'b1));
			s.operands[w] = 16'hFFFF;
			send_sample(s, make_entry(16'hFFFF, w));
		end
		for (int w = 0; w < LANES; w++) begin
			s = fill_sample(16'hFFFF, make_mode(1'b0, 1'b0));
			s.operands[w] = 16'h0000;
			send_sample(s, make_entry(16'h0000, w));
		end
		// Mixed operands, lane 7 first
		s.operands = {16'h3C00, 16'h00FF, 16'hC001, 16'h0F0F,
		              16'h8000, 16'h7FFF, 16'h0010, 16'hBEEF};
		s.mode     = make_mode(1'b0, 1'b1);
		send_sample(s, ref_winner(s));
		s.mode     = make_mode(1'b0, 1'b0);
		send_sample(s, ref_winner(s));
		wait_results();
		report_test("unsigned", err_before);
	endtask

	task automatic test_signed();
		cmp_types_pkg::sample_t s;
		int                     err_before;
		err_before = error_count;
		// Lane 7 first, 8000 sits in lane 5
		s.operands = {16'h0100, 16'h7FFE, 16'h8000, 16'h4000,
		              16'h0001, 16'h7FFF, 16'h1234, 16'h0000};
		// Most negative when signed
		s.mode = make_mode(1'b1, 1'b0);
		send_sample(s, make_entry(16'h8000, 5));
		// Largest magnitude when unsigned
		s.mode = make_mode(1'b0, 1'b1);
		send_sample(s, make_entry(16'h8000, 5));
		s.mode = make_mode(1'b1, 1'b1);
		send_sample(s, make_entry(16'h7FFF, 2));
		s.mode = make_mode(1'b0, 1'b0);
		send_sample(s, make_entry(16'h0000, 0));
		wait_results();
		report_test("signed", err_before);
	endtask

	task automatic test_ties();
		cmp_types_pkg::sample_t s;
		int                     err_before;
		err_before = error_count;
		// All lanes equal, every mode keeps lane 0
		for (int m = 0; m < 4; m++) begin
			s = fill_sample(16'hA5A5, make_mode(m[1], m[0]));
			send_sample(s, make_entry(16'hA5A5, 0));
		end
		// Shared maximum in lanes 3 and 6
		s = fill_sample(16'h0100, make_mode(1'b1, 1'b1));
		s.operands[3] = 16'h7000;
		s.operands[6] = 16'h7000;
		send_sample(s, make_entry(16'h7000, 3));
		// Shared minimum in lanes 3 and 6
		s = fill_sample(16'h0400, make_mode(1'b0, 1'b0));
		s.operands[3] = 16'h0002;
		s.operands[6] = 16'h0002;
		send_sample(s, make_entry(16'h0002, 3));
		wait_results();
		report_test("ties", err_before);
	endtask

	task automatic test_stream();
		cmp_types_pkg::sample_t s;
		int                     err_before;
		err_before = error_count;
		for (int n = 0; n < N_STREAM; n++) begin
			for (int l = 0; l < LANES; l++) begin
				// Every fourth sample draws from a tiny range to force ties
				s.operands[l] = (n % 4 == 3) ? DW'($urandom % 4) : DW'($urandom);
			end
			s.mode = cmp_types_pkg::mode_t'($urandom);
			send_sample(s, ref_winner(s));
		end
		wait_results();
		report_test("stream", err_before);
	endtask

	// =========================================================================
	// Sequence and watchdog
	// =========================================================================

	initial begin
		void'($urandom(32'hdeefaba7));
		i_valid  = 1'b0;
		i_sample = '0;
		i_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#(DRIVE_DELAY);
		i_arst_n = 1'b1;

		test_reset_latency();
		test_unsigned();
		test_signed();
		test_ties();
		test_stream();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
		         test_count, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// One cycle per sample plus reset and drain slack
	initial begin
		#((TOTAL_SAMPLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired, the run did not finish in time");
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: sources.f
logic/cmp_cfg_pkg.sv
logic/cmp_types_pkg.sv
logic/cmp_compress_cell.sv
logic/cmp_compress_tree.sv
logic/magnitude_comparator.sv
logic/tournament_stage.sv
logic/extremum_finder.sv
tests/tb_extremum_finder.sv
